/* bench/display_bus_stimulus.txt */
// port op addr wr_data expected (hex); port 0 CPU, 1 DMA; op 1 write, 0 read
// palette and framebuffer reads give the full written word as expected value
0 1 00000010 cafef00d 00000000
0 0 00000010 00000000 cafef00d
0 1 c0001008 12345678 00000000
0 0 c0001008 00000000 12345678
0 0 c0000000 00000000 d15b0501
0 1 c0000008 aaaa5555 00000000
0 1 c000000c 0badbeef 00000000
0 0 c0000004 00000000 00000002
0 0 c0000008 00000000 aaaa5555
0 0 c000000c 00000000 0badbeef
0 0 80000000 00000000 00000000
0 1 80000010 ffffffff 00000000
0 0 00000010 00000000 cafef00d
1 1 c0020004 11223344 00000000
1 0 c0020004 00000000 11223344
1 1 00000100 deadbeef 00000000
1 1 00000104 01234567 00000000
1 0 00000100 00000000 deadbeef
1 0 00000104 00000000 01234567
1 1 c0001010 ffff8001 00000000
1 0 c0001010 00000000 ffff8001
1 0 c0020004 00000000 11223344

/* verilog.f */
source/bus_pkg.sv
source/video_pkg.sv
source/sync_ram.sv
source/io_registers.sv
source/memory_mapper.sv
source/bus_arbiter.sv
source/display_bus_top.sv
bench/display_bus_assert.sv
bench/display_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the display bus testbench with Verilator, run it, then check the log
rm -f sim.log
verilator --binary --timing --assert --top-module display_bus_tb -f verilog.f \
    -o display_bus_sim > build.log 2>&1 || { cat build.log; echo "FAIL: build"; exit 1; }
./obj_dir/display_bus_sim > sim.log 2>&1 ; cat sim.log
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* bench/display_bus_tb.sv */
// Display bus testbench
// Replays file requests on both ports, checks responses, credits and timeout
module display_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import bus_pkg::*;
    import video_pkg::*;

    localparam int CLK_PERIOD        = 10;
    localparam int QUEUE_DEPTH       = 4;
    localparam int PALETTE_BYTES     = 1024;
    localparam int FRAMEBUFFER_BYTES = 4096;
    localparam int CYCLES_PER_LINE   = 40;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wr_data;
        logic [DATA_W-1:0] expected;
    } request_t;

    logic              clk;
    logic              reset;
    logic              cpu_req_valid, cpu_req_write, dma_req_valid, dma_req_write;
    logic [ADDR_W-1:0] cpu_req_addr, dma_req_addr;
    logic [DATA_W-1:0] cpu_req_wr_data, dma_req_wr_data;
    logic              cpu_credit_return, cpu_rsp_valid, dma_credit_return, dma_rsp_valid;
    logic [DATA_W-1:0] cpu_rsp_data, dma_rsp_data;

    request_t          cpu_reqs[$];
    request_t          dma_reqs[$];
    logic [DATA_W-1:0] cpu_expected[$];
    logic [DATA_W-1:0] dma_expected[$];
    int                sent[2];
    int                credit_count[2];
    int                rsp_count;
    int                read_count;

    display_bus_top #(
        .MAIN_MEMORY_BYTES(4096), .IO_REGISTERS_BYTES(64), .PALETTE_BYTES(PALETTE_BYTES),
        .FRAMEBUFFER_BYTES(FRAMEBUFFER_BYTES), .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_dut (.*);

    bind display_bus_top display_bus_assert i_bus_assert (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // Palette and framebuffer keep only their payload width, zero-extended on read
    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                        input logic [DATA_W-1:0] raw);
        color_t colour;
        pixel_t pixel;
        colour = color_t'(raw[$bits(color_t)-1:0]);
        pixel  = pixel_t'(raw[$bits(pixel_t)-1:0]);
        if (addr >= PALETTE_BASE && addr < PALETTE_BASE + PALETTE_BYTES) begin
            return {{(DATA_W - $bits(color_t)){1'b0}}, colour};
        end else if (addr >= FB_BASE && addr < FB_BASE + FRAMEBUFFER_BYTES) begin
            return {{(DATA_W - $bits(pixel_t)){1'b0}}, pixel};
        end
        return raw;
    endfunction

    task automatic load_stimulus();
        int                fd;
        int                fields;
        string             line;
        logic [31:0]       f_port, f_op;
        logic [ADDR_W-1:0] f_addr;
        logic [DATA_W-1:0] f_data, f_exp;
        request_t          r;
        fd = $fopen("bench/display_bus_stimulus.txt", "r");
        assert (fd != 0) else report_failure("Could not open the stimulus file");
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h %h", f_port, f_op, f_addr, f_data, f_exp);
            // Comment and blank lines do not parse
            if (fields == 5) begin
                r.write    = (req_op_t'(f_op[0]) == OP_WRITE);
                r.addr     = f_addr;
                r.wr_data  = f_data;
                r.expected = expected_read(f_addr, f_exp);
                read_count += r.write ? 0 : 1;
                if (f_port == 0) cpu_reqs.push_back(r);
                else dma_reqs.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_request(input int port, input logic valid, input request_t r);
        if (port == 0) begin
            cpu_req_valid   = valid;
            cpu_req_write   = r.write;
            cpu_req_addr    = r.addr;
            cpu_req_wr_data = r.wr_data;
        end else begin
            dma_req_valid   = valid;
            dma_req_write   = r.write;
            dma_req_addr    = r.addr;
            dma_req_wr_data = r.wr_data;
        end
    endtask

    // One request per cycle while a credit is held
    task automatic drive_port(input int port);
        request_t r;
        int       credits;
        int       index;
        int       total;
        credits = QUEUE_DEPTH;
        index   = 0;
        total   = (port == 0) ? cpu_reqs.size() : dma_reqs.size();
        while (index < total) begin
            @(posedge clk);
            #1;
            if (credits > 0) begin
                r = (port == 0) ? cpu_reqs[index] : dma_reqs[index];
                drive_request(port, 1'b1, r);
                if (!r.write && port == 0) cpu_expected.push_back(r.expected);
                if (!r.write && port == 1) dma_expected.push_back(r.expected);
                credits--;
                index++;
                sent[port]++;
            end else begin
                drive_request(port, 1'b0, '0);
            end
            @(negedge clk);
            if ((port == 0) ? cpu_credit_return : dma_credit_return) credits++;
        end
        @(posedge clk);
        #1;
        drive_request(port, 1'b0, '0);
    endtask

    task automatic watchdog(input int cycles);
        #(cycles * CLK_PERIOD);
        report_failure($sformatf("Timeout after %0d cycles with responses outstanding",
                                 cycles));
    endtask

    // Responses and credits are sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            credit_count[0] += cpu_credit_return ? 1 : 0;
            credit_count[1] += dma_credit_return ? 1 : 0;
            if (cpu_rsp_valid) begin
                assert (cpu_expected.size() > 0)
                    else report_failure("Response on the CPU port with no read outstanding");
                assert (cpu_rsp_data == cpu_expected[0])
                    else report_failure($sformatf("ERR cpu_rsp_data: got %08h, expected %08h",
                                                  cpu_rsp_data, cpu_expected[0]));
                void'(cpu_expected.pop_front());
                rsp_count++;
            end
            if (dma_rsp_valid) begin
                assert (dma_expected.size() > 0)
                    else report_failure("Response on the DMA port with no read outstanding");
                assert (dma_rsp_data == dma_expected[0])
                    else report_failure($sformatf("ERR dma_rsp_data: got %08h, expected %08h",
                                                  dma_rsp_data, dma_expected[0]));
                void'(dma_expected.pop_front());
                rsp_count++;
            end
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        drive_request(0, 1'b0, '0);
        drive_request(1, 1'b0, '0);
        load_stimulus();
        fork
            watchdog((cpu_reqs.size() + dma_reqs.size()) * CYCLES_PER_LINE);
        join_none
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            drive_port(0);
            drive_port(1);
        join
        while (rsp_count < read_count || credit_count[0] < sent[0] ||
               credit_count[1] < sent[1]) begin
            @(posedge clk);
        end
        // Idle a little to catch stray responses or credits
        repeat (4) @(posedge clk);
        assert (credit_count[0] == sent[0])
            else report_failure($sformatf("ERR cpu_credit_return count: got %0h, expected %0h",
                                          credit_count[0], sent[0]));
        assert (credit_count[1] == sent[1])
            else report_failure($sformatf("ERR dma_credit_return count: got %0h, expected %0h",
                                          credit_count[1], sent[1]));
        $display("Test passed");
        $finish;
    end

endmodule

/* bench/display_bus_assert.sv */
// Bus protocol checks for the display bus top level
module display_bus_assert (
    input logic clk,
    input logic reset,
    input logic main_mem_wr_en,
    input logic io_reg_wr_en,
    input logic palette_wr_en,
    input logic fb_wr_en,
    input logic cpu_rsp_valid,
    input logic dma_rsp_valid,
    input logic bus_valid,
    input logic bus_wr_en
);
    timeunit 1ns;
    timeprecision 1ps;

    one_target_write: assert property (@(posedge clk) disable iff (reset)
        $onehot0({main_mem_wr_en, io_reg_wr_en, palette_wr_en, fb_wr_en}))
        else $error("More than one target write enable is high");

    one_response: assert property (@(posedge clk) disable iff (reset)
        !(cpu_rsp_valid && dma_rsp_valid))
        else $error("Both ports received a response in the same cycle");

    // Response exactly one cycle after a read issue
    response_after_read: assert property (@(posedge clk) disable iff (reset)
        (cpu_rsp_valid || dma_rsp_valid) |-> $past(bus_valid && !bus_wr_en))
        else $error("Response without a read issued the cycle before");

endmodule

/* source/display_bus_top.sv */
// Display bus top level
// Arbiter, address decoder, three RAM targets and the I/O register bank
module display_bus_top #(
    parameter logic [bus_pkg::ADDR_W-1:0] MAIN_MEMORY_BASE   = bus_pkg::MAIN_BASE,
    parameter int                         MAIN_MEMORY_BYTES  = 4096,
    parameter logic [bus_pkg::ADDR_W-1:0] IO_REGISTERS_BASE  = bus_pkg::IO_BASE,
    parameter int                         IO_REGISTERS_BYTES = 64,
    parameter logic [bus_pkg::ADDR_W-1:0] PALETTE_BASE       = bus_pkg::PALETTE_BASE,
    parameter int                         PALETTE_BYTES      = 1024,
    parameter logic [bus_pkg::ADDR_W-1:0] FRAMEBUFFER_BASE   = bus_pkg::FB_BASE,
    parameter int                         FRAMEBUFFER_BYTES  = 4096,
    parameter int                         QUEUE_DEPTH        = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cpu_req_valid,
    input  logic                       cpu_req_write,
    input  logic [bus_pkg::ADDR_W-1:0] cpu_req_addr,
    input  logic [bus_pkg::DATA_W-1:0] cpu_req_wr_data,
    output logic                       cpu_credit_return,
    output logic                       cpu_rsp_valid,
    output logic [bus_pkg::DATA_W-1:0] cpu_rsp_data,
    input  logic                       dma_req_valid,
    input  logic                       dma_req_write,
    input  logic [bus_pkg::ADDR_W-1:0] dma_req_addr,
    input  logic [bus_pkg::DATA_W-1:0] dma_req_wr_data,
    output logic                       dma_credit_return,
    output logic                       dma_rsp_valid,
    output logic [bus_pkg::DATA_W-1:0] dma_rsp_data
);
    import bus_pkg::*;
    import video_pkg::*;

    localparam int MAIN_BITS = $clog2(MAIN_MEMORY_BYTES);
    localparam int IO_BITS   = $clog2(IO_REGISTERS_BYTES);
    localparam int PAL_BITS  = $clog2(PALETTE_BYTES);
    localparam int FB_BITS   = $clog2(FRAMEBUFFER_BYTES);

    logic              bus_valid, bus_wr_en;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wr_data, bus_rd_data;

    logic [MAIN_BITS-1:0] main_mem_addr;
    logic [IO_BITS-1:0]   io_reg_addr;
    logic [PAL_BITS-1:0]  palette_addr;
    logic [FB_BITS-1:0]   fb_addr;
    logic [DATA_W-1:0]    main_mem_wr_data, io_reg_wr_data, palette_wr_data, fb_wr_data;
    logic [DATA_W-1:0]    main_mem_rd_data, io_reg_rd_data, palette_rd_data, fb_rd_data;
    logic main_mem_wr_en, io_reg_wr_en, palette_wr_en, fb_wr_en;
    logic main_mem_rd_en, io_reg_rd_en, palette_rd_en, fb_rd_en;

    color_t palette_entry;
    pixel_t fb_pixel;

    bus_arbiter #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_arbiter (.*);

    memory_mapper #(
        .MAIN_MEMORY_BASE(MAIN_MEMORY_BASE),   .MAIN_MEMORY_BYTES(MAIN_MEMORY_BYTES),
        .IO_REGISTERS_BASE(IO_REGISTERS_BASE), .IO_REGISTERS_BYTES(IO_REGISTERS_BYTES),
        .PALETTE_BASE(PALETTE_BASE),           .PALETTE_BYTES(PALETTE_BYTES),
        .FRAMEBUFFER_BASE(FRAMEBUFFER_BASE),   .FRAMEBUFFER_BYTES(FRAMEBUFFER_BYTES)
    ) i_mapper (.*);

    sync_ram #(.DEPTH(MAIN_MEMORY_BYTES / 4), .payload_t(logic [DATA_W-1:0])) i_main_ram (
        .clk, .addr(main_mem_addr[MAIN_BITS-1:2]), .wr_en(main_mem_wr_en),
        .rd_en(main_mem_rd_en), .wr_data(main_mem_wr_data), .rd_data(main_mem_rd_data)
    );

    // Palette keeps the low half-word of a write
    sync_ram #(.DEPTH(PALETTE_BYTES / 4), .payload_t(color_t)) i_palette_ram (
        .clk, .addr(palette_addr[PAL_BITS-1:2]), .wr_en(palette_wr_en),
        .rd_en(palette_rd_en), .wr_data(color_t'(palette_wr_data[$bits(color_t)-1:0])),
        .rd_data(palette_entry)
    );
    assign palette_rd_data = {{(DATA_W - $bits(color_t)){1'b0}}, palette_entry};

    sync_ram #(.DEPTH(FRAMEBUFFER_BYTES / 4), .payload_t(pixel_t)) i_fb_ram (
        .clk, .addr(fb_addr[FB_BITS-1:2]), .wr_en(fb_wr_en), .rd_en(fb_rd_en),
        .wr_data(pixel_t'(fb_wr_data[$bits(pixel_t)-1:0])), .rd_data(fb_pixel)
    );
    assign fb_rd_data = {{(DATA_W - $bits(pixel_t)){1'b0}}, fb_pixel};

    io_registers #(.IO_REGISTERS_BYTES(IO_REGISTERS_BYTES)) i_io_registers (
        .clk, .reset, .addr(io_reg_addr), .wr_data(io_reg_wr_data), .wr_en(io_reg_wr_en),
        .rd_en(io_reg_rd_en), .rd_data(io_reg_rd_data)
    );

endmodule

/* source/bus_arbiter.sv */
// Two-port bus arbiter
// Credit-guarded request queues, round-robin issue and read response routing
module bus_arbiter #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       cpu_req_valid,
    input  logic                       cpu_req_write,
    input  logic [bus_pkg::ADDR_W-1:0] cpu_req_addr,
    input  logic [bus_pkg::DATA_W-1:0] cpu_req_wr_data,
    output logic                       cpu_credit_return,
    output logic                       cpu_rsp_valid,
    output logic [bus_pkg::DATA_W-1:0] cpu_rsp_data,

    input  logic                       dma_req_valid,
    input  logic                       dma_req_write,
    input  logic [bus_pkg::ADDR_W-1:0] dma_req_addr,
    input  logic [bus_pkg::DATA_W-1:0] dma_req_wr_data,
    output logic                       dma_credit_return,
    output logic                       dma_rsp_valid,
    output logic [bus_pkg::DATA_W-1:0] dma_rsp_data,

    output logic                       bus_valid,
    output logic                       bus_wr_en,
    output logic [bus_pkg::ADDR_W-1:0] bus_addr,
    output logic [bus_pkg::DATA_W-1:0] bus_wr_data,
    input  logic [bus_pkg::DATA_W-1:0] bus_rd_data
);
    import bus_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [NUM_PORTS-1:0] push, pop, not_empty;
    logic [ADDR_W-1:0]    in_addr [NUM_PORTS];
    logic [DATA_W-1:0]    in_data [NUM_PORTS];
    req_op_t              in_op   [NUM_PORTS];

    // Queue storage
    req_op_t           q_op   [NUM_PORTS][QUEUE_DEPTH];
    logic [ADDR_W-1:0] q_addr [NUM_PORTS][QUEUE_DEPTH];
    logic [DATA_W-1:0] q_data [NUM_PORTS][QUEUE_DEPTH];

    logic [PTR_W-1:0]  wr_ptr [NUM_PORTS];
    logic [PTR_W-1:0]  rd_ptr [NUM_PORTS];
    logic [PTR_W:0]    count  [NUM_PORTS];

    port_id_t grant, last_grant, rsp_port;
    logic     rsp_pending;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        push       = {dma_req_valid, cpu_req_valid};
        in_addr[0] = cpu_req_addr;
        in_addr[1] = dma_req_addr;
        in_data[0] = cpu_req_wr_data;
        in_data[1] = dma_req_wr_data;
        in_op[0]   = cpu_req_write ? OP_WRITE : OP_READ;
        in_op[1]   = dma_req_write ? OP_WRITE : OP_READ;
        for (int p = 0; p < NUM_PORTS; p++) begin
            not_empty[p] = (count[p] != '0);
        end
    end

    // Round robin: the other port wins when both wait
    always_comb begin
        if (&not_empty) begin
            grant = ~last_grant;
        end else begin
            grant = not_empty[1];
        end
        pop        = '0;
        pop[grant] = |not_empty;
    end

    assign bus_valid         = |not_empty;
    assign bus_wr_en         = bus_valid && (q_op[grant][rd_ptr[grant]] == OP_WRITE);
    assign bus_addr          = q_addr[grant][rd_ptr[grant]];
    assign bus_wr_data       = q_data[grant][rd_ptr[grant]];
    assign cpu_credit_return = pop[0];
    assign dma_credit_return = pop[1];

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (push[p]) begin
                q_op[p][wr_ptr[p]]   <= in_op[p];
                q_addr[p][wr_ptr[p]] <= in_addr[p];
                q_data[p][wr_ptr[p]] <= in_data[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            last_grant  <= 1'b1;
            rsp_pending <= 1'b0;
            rsp_port    <= 1'b0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (push[p]) begin
                    wr_ptr[p] <= next_ptr(wr_ptr[p]);
                end
                if (pop[p]) begin
                    rd_ptr[p] <= next_ptr(rd_ptr[p]);
                end
                if (push[p] && !pop[p]) begin
                    count[p] <= count[p] + 1'b1;
                end else if (pop[p] && !push[p]) begin
                    count[p] <= count[p] - 1'b1;
                end
            end
            if (bus_valid) begin
                last_grant <= grant;
            end
            // A read answers one cycle after it issues
            rsp_pending <= bus_valid && !bus_wr_en;
            rsp_port    <= grant;
        end
    end

    assign cpu_rsp_valid = rsp_pending && (rsp_port == 1'b0);
    assign dma_rsp_valid = rsp_pending && (rsp_port == 1'b1);
    assign cpu_rsp_data  = cpu_rsp_valid ? bus_rd_data : '0;
    assign dma_rsp_data  = dma_rsp_valid ? bus_rd_data : '0;

endmodule

/* source/memory_mapper.sv */
// Address decoder for the display bus
// Base addresses must be multiples of their region size rounded up to a power of two
module memory_mapper #(
    parameter logic [bus_pkg::ADDR_W-1:0] MAIN_MEMORY_BASE  = bus_pkg::MAIN_BASE,
    parameter int                         MAIN_MEMORY_BYTES = 4096,
    parameter logic [bus_pkg::ADDR_W-1:0] IO_REGISTERS_BASE = bus_pkg::IO_BASE,
    parameter int                         IO_REGISTERS_BYTES = 64,
    parameter logic [bus_pkg::ADDR_W-1:0] PALETTE_BASE      = bus_pkg::PALETTE_BASE,
    parameter int                         PALETTE_BYTES     = 1024,
    parameter logic [bus_pkg::ADDR_W-1:0] FRAMEBUFFER_BASE  = bus_pkg::FB_BASE,
    parameter int                         FRAMEBUFFER_BYTES = 4096
) (
    input  logic                                  clk,
    input  logic                                  reset,

    // Shared bus from the arbiter
    input  logic                                  bus_valid,
    input  logic                                  bus_wr_en,
    input  logic [bus_pkg::ADDR_W-1:0]            bus_addr,
    input  logic [bus_pkg::DATA_W-1:0]            bus_wr_data,
    output logic [bus_pkg::DATA_W-1:0]            bus_rd_data,

    output logic [$clog2(MAIN_MEMORY_BYTES)-1:0]  main_mem_addr,
    output logic [bus_pkg::DATA_W-1:0]            main_mem_wr_data,
    output logic                                  main_mem_wr_en,
    output logic                                  main_mem_rd_en,
    input  logic [bus_pkg::DATA_W-1:0]            main_mem_rd_data,

    output logic [$clog2(IO_REGISTERS_BYTES)-1:0] io_reg_addr,
    output logic [bus_pkg::DATA_W-1:0]            io_reg_wr_data,
    output logic                                  io_reg_wr_en,
    output logic                                  io_reg_rd_en,
    input  logic [bus_pkg::DATA_W-1:0]            io_reg_rd_data,

    output logic [$clog2(PALETTE_BYTES)-1:0]      palette_addr,
    output logic [bus_pkg::DATA_W-1:0]            palette_wr_data,
    output logic                                  palette_wr_en,
    output logic                                  palette_rd_en,
    input  logic [bus_pkg::DATA_W-1:0]            palette_rd_data,

    output logic [$clog2(FRAMEBUFFER_BYTES)-1:0]  fb_addr,
    output logic [bus_pkg::DATA_W-1:0]            fb_wr_data,
    output logic                                  fb_wr_en,
    output logic                                  fb_rd_en,
    input  logic [bus_pkg::DATA_W-1:0]            fb_rd_data
);
    import bus_pkg::*;

    localparam int MAIN_BITS = $clog2(MAIN_MEMORY_BYTES);
    localparam int IO_BITS   = $clog2(IO_REGISTERS_BYTES);
    localparam int PAL_BITS  = $clog2(PALETTE_BYTES);
    localparam int FB_BITS   = $clog2(FRAMEBUFFER_BYTES);

    logic hit_main, hit_io, hit_palette, hit_fb;
    logic sel_main, sel_io, sel_palette, sel_fb;

    // Upper address bits identify the target
    assign hit_main    = bus_valid &&
                         (bus_addr[ADDR_W-1:MAIN_BITS] == MAIN_MEMORY_BASE[ADDR_W-1:MAIN_BITS]);
    assign hit_io      = bus_valid &&
                         (bus_addr[ADDR_W-1:IO_BITS] == IO_REGISTERS_BASE[ADDR_W-1:IO_BITS]);
    assign hit_palette = bus_valid &&
                         (bus_addr[ADDR_W-1:PAL_BITS] == PALETTE_BASE[ADDR_W-1:PAL_BITS]);
    assign hit_fb      = bus_valid &&
                         (bus_addr[ADDR_W-1:FB_BITS] == FRAMEBUFFER_BASE[ADDR_W-1:FB_BITS]);

    always_comb begin
        main_mem_addr    = bus_addr[MAIN_BITS-1:0];
        main_mem_wr_data = bus_wr_data;
        main_mem_wr_en   = hit_main && bus_wr_en;
        main_mem_rd_en   = hit_main && !bus_wr_en;

        io_reg_addr      = bus_addr[IO_BITS-1:0];
        io_reg_wr_data   = bus_wr_data;
        io_reg_wr_en     = hit_io && bus_wr_en;
        io_reg_rd_en     = hit_io && !bus_wr_en;

        palette_addr     = bus_addr[PAL_BITS-1:0];
        palette_wr_data  = bus_wr_data;
        palette_wr_en    = hit_palette && bus_wr_en;
        palette_rd_en    = hit_palette && !bus_wr_en;

        fb_addr          = bus_addr[FB_BITS-1:0];
        fb_wr_data       = bus_wr_data;
        fb_wr_en         = hit_fb && bus_wr_en;
        fb_rd_en         = hit_fb && !bus_wr_en;
    end

    // Remember which target answers next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            {sel_main, sel_io, sel_palette, sel_fb} <= '0;
        end else begin
            {sel_main, sel_io, sel_palette, sel_fb} <=
                {main_mem_rd_en, io_reg_rd_en, palette_rd_en, fb_rd_en};
        end
    end

    always_comb begin
        if (sel_main) begin
            bus_rd_data = main_mem_rd_data;
        end else if (sel_io) begin
            bus_rd_data = io_reg_rd_data;
        end else if (sel_palette) begin
            bus_rd_data = palette_rd_data;
        end else if (sel_fb) begin
            bus_rd_data = fb_rd_data;
        end else begin
            // Unmapped read
            bus_rd_data = '0;
        end
    end

endmodule

/* source/io_registers.sv */
// I/O register bank
// Word 0 is the ID, word 1 counts scratch writes, words 2 to 7 are scratch
module io_registers #(
    parameter int IO_REGISTERS_BYTES = 64
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [$clog2(IO_REGISTERS_BYTES)-1:0] addr,
    input  logic [bus_pkg::DATA_W-1:0]            wr_data,
    input  logic                                  wr_en,
    input  logic                                  rd_en,
    output logic [bus_pkg::DATA_W-1:0]            rd_data
);
    import bus_pkg::*;

    localparam int ADDR_BITS = $clog2(IO_REGISTERS_BYTES);

    logic [ADDR_BITS-3:0] word;
    logic                 is_scratch;
    logic [DATA_W-1:0]    write_count;
    logic [DATA_W-1:0]    scratch [2:7];

    assign word       = addr[ADDR_BITS-1:2];
    assign is_scratch = (word >= 2) && (word <= 7);

    // Only writes that land on a scratch word are accepted and counted
    always_ff @(posedge clk) begin
        if (reset) begin
            write_count <= '0;
            for (int i = 2; i <= 7; i++) begin
                scratch[i] <= '0;
            end
        end else if (wr_en && is_scratch) begin
            write_count   <= write_count + 1'b1;
            scratch[word] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (word == 0) begin
                rd_data <= IO_ID_VALUE;
            end else if (word == 1) begin
                rd_data <= write_count;
            end else if (is_scratch) begin
                rd_data <= scratch[word];
            end else begin
                rd_data <= '0;
            end
        end
    end

endmodule

/* source/sync_ram.sv */
// Synchronous single-port RAM
// Word addressed, payload set by type parameter, one-cycle registered read
module sync_ram #(
    parameter int DEPTH = 256,
    parameter type payload_t = logic [31:0]
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     wr_en,
    input  logic                     rd_en,
    input  payload_t                 wr_data,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
        // Read returns the old word on a same-cycle write
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

/* source/video_pkg.sv */
// Video payload types
// Palette colours and framebuffer pixels as stored in their RAMs
package video_pkg;

    // RGB565 palette entry
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } color_t;

    // Framebuffer pixel, an index into the palette
    typedef logic [7:0] pixel_t;

endpackage

/* source/bus_pkg.sv */
// Display bus definitions
// Widths, port count, default address map and request opcodes
package bus_pkg;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // Requesters sharing the bus: CPU and DMA
    parameter int NUM_PORTS = 2;

    typedef logic port_id_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_t;

    // Default map; the top level passes the real bases down
    parameter logic [ADDR_W-1:0] MAIN_BASE    = 32'h0000_0000;
    parameter logic [ADDR_W-1:0] IO_BASE      = 32'hC000_0000;
    parameter logic [ADDR_W-1:0] PALETTE_BASE = 32'hC000_1000;
    parameter logic [ADDR_W-1:0] FB_BASE      = 32'hC002_0000;

    // Returned by word 0 of the I/O register bank
    parameter logic [DATA_W-1:0] IO_ID_VALUE = 32'hD15B_0501;

endpackage
